// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FLAGS     ?= -j 0
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f flist.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
logic/soc_pkg.sv
logic/cycle_counter.sv
logic/ctrl_regs.sv
logic/l2_mem.sv
logic/apb_bridge_fsm.sv
logic/bus_decoder.sv
logic/soc_periph_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: logic/apb_bridge_fsm.sv
/* Wishbone to APB bridge FSM: setup, access, then one reply cycle */

module apb_bridge_fsm (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::wb_req_t  req_i,
  output soc_pkg::wb_rsp_t  rsp_o,
  output soc_pkg::apb_req_t apb_o,
  input  soc_pkg::apb_rsp_t apb_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    DONE
  } state_e;

  state_e                         state_d;
  state_e                         state_q;
  logic                           start;
  logic                           pwrite_q;
  logic [soc_pkg::ADDR_WIDTH-1:0] paddr_q;
  logic [soc_pkg::DATA_WIDTH-1:0] pwdata_q;
  logic [soc_pkg::SEL_WIDTH-1:0]  pstrb_q;
  logic [soc_pkg::DATA_WIDTH-1:0] prdata_q;
  logic                           pslverr_q;

  assign start = (state_q == IDLE) & req_i.cyc & req_i.stb;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (start) state_d = SETUP;
      SETUP:   state_d = ACCESS;
      ACCESS:  if (apb_i.pready) state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else state_q <= state_d;
  end

  // Transfer payload, held for the whole APB transfer
  always_ff @(posedge clk_i) begin
    if (start) begin
      pwrite_q <= req_i.we;
      paddr_q  <= req_i.adr - soc_pkg::UART_BASE;
      pwdata_q <= req_i.dat;
      pstrb_q  <= req_i.sel;
    end
    if (state_q == ACCESS && apb_i.pready) begin
      prdata_q  <= apb_i.prdata;
      pslverr_q <= apb_i.pslverr;
    end
  end

  always_comb begin
    apb_o.psel    = (state_q == SETUP) | (state_q == ACCESS);
    apb_o.penable = state_q == ACCESS;
    apb_o.pwrite  = pwrite_q;
    apb_o.paddr   = paddr_q;
    apb_o.pwdata  = pwdata_q;
    apb_o.pstrb   = pstrb_q;
  end

  // pslverr turns into a Wishbone err
  assign rsp_o.ack = (state_q == DONE) & ~pslverr_q;
  assign rsp_o.err = (state_q == DONE) & pslverr_q;
  assign rsp_o.dat = prdata_q;

endmodule

// File: logic/bus_decoder.sv
/* Address decoder: routes one Wishbone request to a slave,
   muxes the replies and answers unmapped addresses with err */

module bus_decoder (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t wb_req_i,
  output soc_pkg::wb_rsp_t wb_rsp_o,
  output soc_pkg::wb_req_t l2_req_o,
  output soc_pkg::wb_req_t ctrl_req_o,
  output soc_pkg::wb_req_t uart_req_o,
  input  soc_pkg::wb_rsp_t l2_rsp_i,
  input  soc_pkg::wb_rsp_t ctrl_rsp_i,
  input  soc_pkg::wb_rsp_t uart_rsp_i
);

  soc_pkg::slave_e sel_d;
  soc_pkg::slave_e sel_q;
  logic            req_valid;
  logic            err_q;

  assign req_valid = wb_req_i.cyc & wb_req_i.stb;

  // Unsigned offset compare covers both region bounds
  always_comb begin
    if (wb_req_i.adr - soc_pkg::DRAM_BASE < soc_pkg::DRAM_LENGTH) begin
      sel_d = soc_pkg::L2MEM;
    end else if (wb_req_i.adr - soc_pkg::UART_BASE < soc_pkg::UART_LENGTH) begin
      sel_d = soc_pkg::UART;
    end else if (wb_req_i.adr - soc_pkg::CTRL_BASE < soc_pkg::CTRL_LENGTH) begin
      sel_d = soc_pkg::CTRL;
    end else begin
      sel_d = soc_pkg::NONE;
    end
  end

  // Only the addressed slave sees cyc and stb
  always_comb begin
    l2_req_o       = wb_req_i;
    l2_req_o.cyc   = wb_req_i.cyc & (sel_d == soc_pkg::L2MEM);
    l2_req_o.stb   = wb_req_i.stb & (sel_d == soc_pkg::L2MEM);
    ctrl_req_o     = wb_req_i;
    ctrl_req_o.cyc = wb_req_i.cyc & (sel_d == soc_pkg::CTRL);
    ctrl_req_o.stb = wb_req_i.stb & (sel_d == soc_pkg::CTRL);
    uart_req_o     = wb_req_i;
    uart_req_o.cyc = wb_req_i.cyc & (sel_d == soc_pkg::UART);
    uart_req_o.stb = wb_req_i.stb & (sel_d == soc_pkg::UART);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= soc_pkg::NONE;
      err_q <= 1'b0;
    end else begin
      if (req_valid) begin
        sel_q <= sel_d;
      end
      // One err pulse per unmapped request
      err_q <= req_valid & (sel_d == soc_pkg::NONE) & ~err_q;
    end
  end

  always_comb begin
    unique case (sel_q)
      soc_pkg::L2MEM: wb_rsp_o = l2_rsp_i;
      soc_pkg::UART:  wb_rsp_o = uart_rsp_i;
      soc_pkg::CTRL:  wb_rsp_o = ctrl_rsp_i;
      default: begin
        wb_rsp_o     = '0;
        wb_rsp_o.err = err_q;
      end
    endcase
  end

endmodule

// File: logic/ctrl_regs.sv
/* Control registers: exit, counter enable and the cycle counter port */

module ctrl_regs (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o,
  output logic [31:0]      exit_o,
  output logic [31:0]      hw_cnt_en_o
);

  localparam int unsigned OFFS_WIDTH = $clog2(soc_pkg::CTRL_LENGTH);

  logic [OFFS_WIDTH-3:0]          word_offs;
  logic                           valid;
  logic                           is_exit;
  logic                           is_cnt_en;
  logic                           is_cycles;
  logic                           cnt_load;
  logic                           ack_q;
  logic [31:0]                    exit_q;
  logic [31:0]                    hw_cnt_en_q;
  logic [31:0]                    count;
  logic [soc_pkg::DATA_WIDTH-1:0] rdata_d;
  logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;

  assign valid     = req_i.cyc & req_i.stb & ~ack_q;
  assign word_offs = req_i.adr[OFFS_WIDTH-1:2];
  assign is_exit   = word_offs == soc_pkg::CTRL_EXIT_OFFSET[OFFS_WIDTH-1:2];
  assign is_cnt_en = word_offs == soc_pkg::CTRL_CNT_EN_OFFSET[OFFS_WIDTH-1:2];
  assign is_cycles = word_offs == soc_pkg::CTRL_CYCLES_OFFSET[OFFS_WIDTH-1:2];
  assign cnt_load  = valid & req_i.we & is_cycles;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q       <= 1'b0;
      exit_q      <= '0;
      hw_cnt_en_q <= '0;
    end else begin
      ack_q <= valid;
      if (valid && req_i.we) begin
        for (int b = 0; b < soc_pkg::SEL_WIDTH; b++) begin
          if (req_i.sel[b] && is_exit) exit_q[8*b +: 8] <= req_i.dat[8*b +: 8];
          if (req_i.sel[b] && is_cnt_en) hw_cnt_en_q[8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  // Unused offsets read zero
  always_comb begin
    rdata_d = '0;
    if (is_exit) rdata_d = exit_q;
    if (is_cnt_en) rdata_d = hw_cnt_en_q;
    if (is_cycles) rdata_d = count;
  end

  always_ff @(posedge clk_i) begin
    if (valid) rdata_q <= rdata_d;
  end

  cycle_counter i_cycle_counter (
    .clk_i      (clk_i         ),
    .rst_n_i    (rst_n_i       ),
    .en_i       (hw_cnt_en_q[0]),
    .load_i     (cnt_load      ),
    .load_val_i (req_i.dat     ),
    .count_o    (count         )
  );

  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.dat   = rdata_q;
  assign exit_o      = exit_q;
  assign hw_cnt_en_o = hw_cnt_en_q;

endmodule

// File: logic/cycle_counter.sv
/* Loadable free-running cycle counter */

module cycle_counter (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        en_i,
  input  logic        load_i,
  input  logic [31:0] load_val_i,
  output logic [31:0] count_o
);

  logic [31:0] count_q;

  // Load wins over counting, wraps at 2^32
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (load_i) begin
      count_q <= load_val_i;
    end else if (en_i) begin
      count_q <= count_q + 32'd1;
    end
  end

  assign count_o = count_q;

endmodule

// File: logic/l2_mem.sv
/* Word-addressed L2 memory with byte selects and one-cycle ack */

module l2_mem #(
  parameter int unsigned L2_NUM_WORDS = 1024
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  soc_pkg::wb_req_t req_i,
  output soc_pkg::wb_rsp_t rsp_o
);

  localparam int unsigned IDX_WIDTH = $clog2(L2_NUM_WORDS);

  logic [soc_pkg::DATA_WIDTH-1:0] mem_q [L2_NUM_WORDS];
  logic [soc_pkg::DATA_WIDTH-1:0] rdata_q;
  logic [IDX_WIDTH-1:0]           idx;
  logic                           valid;
  logic                           ack_q;

  // Upper address bits alias
  assign idx   = req_i.adr[IDX_WIDTH+1:2];
  assign valid = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_q <= '{default: '0};
      ack_q <= 1'b0;
    end else begin
      ack_q <= valid;
      if (valid && req_i.we) begin
        for (int b = 0; b < soc_pkg::SEL_WIDTH; b++) begin
          if (req_i.sel[b]) mem_q[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid) rdata_q <= mem_q[idx];
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;

endmodule

// File: logic/soc_periph_top.sv
/* Peripheral subsystem top: Wishbone decoder, L2 memory,
   control registers and the APB bridge to the UART */

module soc_periph_top #(
  parameter int unsigned L2_NUM_WORDS = 1024
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Wishbone slave port
  input  soc_pkg::wb_req_t        wb_req_i,
  output soc_pkg::wb_rsp_t        wb_rsp_o,
  // UART APB port
  output soc_pkg::apb_req_t       uart_apb_o,
  input  soc_pkg::apb_rsp_t       uart_apb_i,
  // Control outputs
  output logic [31:0]             exit_o,
  output logic [31:0]             hw_cnt_en_o
);

  soc_pkg::wb_req_t l2_req;
  soc_pkg::wb_rsp_t l2_rsp;
  soc_pkg::wb_req_t ctrl_req;
  soc_pkg::wb_rsp_t ctrl_rsp;
  soc_pkg::wb_req_t uart_req;
  soc_pkg::wb_rsp_t uart_rsp;

  //////////////////////////////
  // Crossbar
  //////////////////////////////

  bus_decoder i_bus_decoder (
    .clk_i      (clk_i   ),
    .rst_n_i    (rst_n_i ),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .l2_req_o   (l2_req  ),
    .ctrl_req_o (ctrl_req),
    .uart_req_o (uart_req),
    .l2_rsp_i   (l2_rsp  ),
    .ctrl_rsp_i (ctrl_rsp),
    .uart_rsp_i (uart_rsp)
  );

  //////////////////////////////
  // Slaves
  //////////////////////////////

  l2_mem #(
    .L2_NUM_WORDS (L2_NUM_WORDS)
  ) i_l2_mem (
    .clk_i   (clk_i  ),
    .rst_n_i (rst_n_i),
    .req_i   (l2_req ),
    .rsp_o   (l2_rsp )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .req_i       (ctrl_req   ),
    .rsp_o       (ctrl_rsp   ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

  apb_bridge_fsm i_uart_bridge (
    .clk_i   (clk_i     ),
    .rst_n_i (rst_n_i   ),
    .req_i   (uart_req  ),
    .rsp_o   (uart_rsp  ),
    .apb_o   (uart_apb_o),
    .apb_i   (uart_apb_i)
  );

endmodule

// File: logic/soc_pkg.sv
/* Bus widths, peripheral address map, control register offsets
   and the Wishbone and APB request/reply structs */

package soc_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned SEL_WIDTH  = DATA_WIDTH / 8;

  //////////////////////////////
  // Memory map
  //////////////////////////////

  // 1 GiB of DRAM, aliased onto the L2 array
  localparam logic [ADDR_WIDTH-1:0] DRAM_BASE   = 32'h8000_0000;
  localparam logic [ADDR_WIDTH-1:0] DRAM_LENGTH = 32'h4000_0000;
  localparam logic [ADDR_WIDTH-1:0] UART_BASE   = 32'hC000_0000;
  localparam logic [ADDR_WIDTH-1:0] UART_LENGTH = 32'h0000_1000;
  localparam logic [ADDR_WIDTH-1:0] CTRL_BASE   = 32'hD000_0000;
  localparam logic [ADDR_WIDTH-1:0] CTRL_LENGTH = 32'h0000_1000;

  // Byte offsets inside the control region
  localparam logic [ADDR_WIDTH-1:0] CTRL_EXIT_OFFSET   = 32'h0;
  localparam logic [ADDR_WIDTH-1:0] CTRL_CNT_EN_OFFSET = 32'h4;
  localparam logic [ADDR_WIDTH-1:0] CTRL_CYCLES_OFFSET = 32'h8;

  // Routing targets of the decoder
  typedef enum logic [1:0] {
    L2MEM = 2'd0,
    UART  = 2'd1,
    CTRL  = 2'd2,
    NONE  = 2'd3
  } slave_e;

  //////////////////////////////
  // Bus structs
  //////////////////////////////

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat;
    logic [SEL_WIDTH-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic                  ack;
    logic                  err;
    logic [DATA_WIDTH-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_WIDTH-1:0] paddr;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [SEL_WIDTH-1:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic                  pready;
    logic                  pslverr;
    logic [DATA_WIDTH-1:0] prdata;
  } apb_rsp_t;

endpackage

// File: tb/tb_checker.sv
/* Bus checker: models L2, control registers and the UART array,
   compares each completed Wishbone cycle and its APB transfer */

module tb_checker (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  soc_pkg::wb_req_t  wb_req_i,
  input  soc_pkg::wb_rsp_t  wb_rsp_i,
  input  soc_pkg::apb_req_t apb_req_i,
  input  soc_pkg::apb_rsp_t apb_rsp_i,
  input  logic [31:0]       exit_i,
  input  logic [31:0]       cnt_en_i,
  output int                errors_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] l2_model [1024];
  logic [31:0] uart_model [1024];
  logic [31:0] exit_m;
  logic [31:0] cnt_en_m;
  logic [31:0] count_m;
  logic        count_known;
  logic        prev_psel;
  logic        prev_reply;
  int          xfers;

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] dat,
                                        input logic [3:0] sel);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = dat[8*b +: 8];
    end
    return res;
  endfunction

  task automatic fail(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors_o++;
  endtask

  always @(posedge clk_i) begin
    logic [31:0] adr;
    logic [9:0]  idx;
    logic        exp_err;
    adr = wb_req_i.adr;
    idx = adr[11:2];
    if (!rst_n_i) begin
      errors_o    = 0;
      exit_m      = '0;
      cnt_en_m    = '0;
      count_m     = '0;
      count_known = 1'b1;
      prev_psel   = 1'b0;
      prev_reply  = 1'b0;
      xfers       = 0;
      for (int i = 0; i < 1024; i++) begin
        l2_model[i]   = '0;
        uart_model[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
      end
    end else begin
      ////////////////////////////// APB side
      if (apb_req_i.penable && !apb_req_i.psel) fail("penable high without psel");
      if (apb_req_i.psel && apb_req_i.penable && !prev_psel) fail("access phase without setup");
      if (apb_req_i.psel && apb_req_i.penable && apb_rsp_i.pready) begin
        xfers++;
        if (apb_req_i.paddr !== adr - 32'hC000_0000 || apb_req_i.pwrite !== wb_req_i.we)
          fail($sformatf("apb paddr %h pwrite %b for adr %h", apb_req_i.paddr,
                         apb_req_i.pwrite, adr));
        if (wb_req_i.we && (apb_req_i.pwdata !== wb_req_i.dat || apb_req_i.pstrb !== wb_req_i.sel))
          fail($sformatf("apb pwdata %h pstrb %h", apb_req_i.pwdata, apb_req_i.pstrb));
      end
      prev_psel = apb_req_i.psel;

      ////////////////////////////// Wishbone completion
      if (wb_rsp_i.ack && wb_rsp_i.err) fail("ack and err together");
      // A reply lasts one cycle and only answers a live request
      if ((wb_rsp_i.ack || wb_rsp_i.err) && prev_reply) fail("reply held for more than one cycle");
      if ((wb_rsp_i.ack || wb_rsp_i.err) && !(wb_req_i.cyc && wb_req_i.stb))
        fail("reply without a request");
      prev_reply = wb_rsp_i.ack | wb_rsp_i.err;
      if (wb_req_i.cyc && wb_req_i.stb && (wb_rsp_i.ack || wb_rsp_i.err)) begin
        exp_err = 1'b0;
        if (adr[31:30] == 2'b10) begin
          if (!wb_req_i.we && wb_rsp_i.dat !== l2_model[idx])
            fail($sformatf("l2 read %h got %h exp %h", adr, wb_rsp_i.dat, l2_model[idx]));
          if (wb_req_i.we) l2_model[idx] = merge(l2_model[idx], wb_req_i.dat, wb_req_i.sel);
        end else if (adr[31:12] == 20'hC0000) begin
          exp_err = adr[11];
          if (!exp_err && !wb_req_i.we && wb_rsp_i.dat !== uart_model[idx])
            fail($sformatf("uart read %h got %h exp %h", adr, wb_rsp_i.dat, uart_model[idx]));
          if (!exp_err && wb_req_i.we)
            uart_model[idx] = merge(uart_model[idx], wb_req_i.dat, wb_req_i.sel);
          if (xfers != 1) fail($sformatf("%0d apb transfers for adr %h", xfers, adr));
        end else if (adr[31:12] == 20'hD0000) begin
          if (wb_req_i.we) begin
            if (idx == 10'd0) exit_m = merge(exit_m, wb_req_i.dat, wb_req_i.sel);
            if (idx == 10'd1) cnt_en_m = merge(cnt_en_m, wb_req_i.dat, wb_req_i.sel);
            if (idx == 10'd2) count_m = wb_req_i.dat;
            if (idx == 10'd2) count_known = !cnt_en_m[0];
            if (cnt_en_m[0]) count_known = 1'b0;
          end else if (idx == 10'd0 && wb_rsp_i.dat !== exit_m) begin
            fail($sformatf("exit read %h exp %h", wb_rsp_i.dat, exit_m));
          end else if (idx == 10'd1 && wb_rsp_i.dat !== cnt_en_m) begin
            fail($sformatf("cnt_en read %h exp %h", wb_rsp_i.dat, cnt_en_m));
          end else if (idx == 10'd2 && !cnt_en_m[0]) begin
            // A stopped counter with unknown value is learned from this read
            if (count_known && wb_rsp_i.dat !== count_m)
              fail($sformatf("cycles read %h exp %h", wb_rsp_i.dat, count_m));
            count_m     = wb_rsp_i.dat;
            count_known = 1'b1;
          end else if (idx > 10'd2 && wb_rsp_i.dat !== 32'h0) begin
            fail($sformatf("unused ctrl offset %h read %h", adr, wb_rsp_i.dat));
          end
        end else begin
          exp_err = 1'b1;
          if (!wb_req_i.we && wb_rsp_i.dat !== 32'h0) fail("unmapped read data not zero");
        end
        if (wb_rsp_i.err !== exp_err)
          fail($sformatf("adr %h ended with err=%b, expected %b", adr, wb_rsp_i.err, exp_err));
        if (adr[31:12] != 20'hC0000 && xfers != 0) fail("apb transfer outside uart region");
        if (exit_i !== exit_m || cnt_en_i !== cnt_en_m)
          fail($sformatf("exit_o %h hw_cnt_en_o %h exp %h %h", exit_i, cnt_en_i, exit_m, cnt_en_m));
        xfers = 0;
      end
    end
  end

endmodule

// File: tb/tb_top.sv
/* Testbench top: clock, reset, random Wishbone traffic per region,
   APB slave responder with wait states, per-test report */

module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 64;

  logic                clk_i;
  logic                rst_n_i;
  soc_pkg::wb_req_t    wb_req;
  soc_pkg::wb_rsp_t    wb_rsp;
  soc_pkg::apb_req_t   apb_req;
  soc_pkg::apb_rsp_t   apb_rsp;
  logic [31:0]         exit_w;
  logic [31:0]         cnt_en_w;
  logic [31:0]         uart_mem [1024];
  integer              seed;
  integer              wait_seed;
  int                  wait_left;
  int                  tb_errors;
  int                  checker_errors;
  int                  tests_passed;
  int                  tests_failed;

  always #10 clk_i = ~clk_i;

  soc_periph_top #(
    .L2_NUM_WORDS (1024)
  ) i_dut (
    .clk_i       (clk_i   ),
    .rst_n_i     (rst_n_i ),
    .wb_req_i    (wb_req  ),
    .wb_rsp_o    (wb_rsp  ),
    .uart_apb_o  (apb_req ),
    .uart_apb_i  (apb_rsp ),
    .exit_o      (exit_w  ),
    .hw_cnt_en_o (cnt_en_w)
  );

  tb_checker i_checker (
    .clk_i     (clk_i             ),
    .rst_n_i   (rst_n_i           ),
    .wb_req_i  (i_dut.wb_req_i    ),
    .wb_rsp_i  (i_dut.wb_rsp_o    ),
    .apb_req_i (i_dut.uart_apb_o  ),
    .apb_rsp_i (i_dut.uart_apb_i  ),
    .exit_i    (i_dut.exit_o      ),
    .cnt_en_i  (i_dut.hw_cnt_en_o ),
    .errors_o  (checker_errors    )
  );

  //////////////////////////////
  // APB responder
  //////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_n_i || !apb_req.psel) begin
      apb_rsp = '0;
    end else if (!apb_req.penable) begin
      wait_left = {$random(wait_seed)} % 4;
    end else if (!apb_rsp.pready) begin
      if (wait_left == 0) begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = apb_req.paddr >= 32'h800;
        apb_rsp.prdata  = uart_mem[apb_req.paddr[11:2]];
        if (apb_req.pwrite && !apb_rsp.pslverr) begin
          for (int b = 0; b < 4; b++) begin
            if (apb_req.pstrb[b])
              uart_mem[apb_req.paddr[11:2]][8*b +: 8] = apb_req.pwdata[8*b +: 8];
          end
        end
      end else begin
        wait_left--;
      end
    end
  end

  // One classic cycle, started and ended on a falling edge
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, output logic [31:0] rdata);
    int   cycles;
    logic done;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    done   = 1'b0;
    cycles = 0;
    rdata  = '0;
    while (!done && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
      if (wb_rsp.ack || wb_rsp.err) begin
        done  = 1'b1;
        rdata = wb_rsp.dat;
      end
    end
    if (!done) begin
      $display("Timeout: no ack or err for address %h after %0d cycles", adr, cycles);
      tb_errors++;
    end
    @(negedge clk_i);
    wb_req = '0;
  endtask

  function automatic logic [31:0] gen_addr(input int kind, input logic [31:0] r);
    case (kind)
      0:       return {2'b10, r[29:2], 2'b00};
      1:       return {20'hD0000, 6'd0, r[5:2], 2'b00};
      2:       return {20'hC0000, 1'b0, r[10:2], 2'b00};
      3:       return {20'hC0000, r[11:2], 2'b00};
      default: return {r[31] ? {1'b0, r[30:28]} : {3'b111, r[28]}, r[27:2], 2'b00};
    endcase
  endfunction

  task automatic random_traffic(input int kind, input int count, input logic writes_only);
    logic [31:0] r;
    logic [31:0] rdata;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      bus_access(writes_only | r[0], gen_addr(kind, $random(seed)), $random(seed), r[7:4], rdata);
    end
  endtask

  task automatic report_test(input string name, input int mark);
    int    errs;
    string verdict;
    errs = tb_errors + checker_errors - mark;
    if (errs == 0) begin
      tests_passed++;
      verdict = "ok";
    end else begin
      tests_failed++;
      verdict = "failed";
    end
    $display("Test %-24s %s (%0d errors)", name, verdict, errs);
  endtask

  task automatic counter_test();
    logic [31:0] load_val;
    logic [31:0] r1;
    logic [31:0] r2;
    load_val = $random(seed);
    bus_access(1'b1, 32'hD000_0004, 32'h0, 4'hF, r1);
    bus_access(1'b1, 32'hD000_0008, load_val, 4'hF, r1);
    bus_access(1'b0, 32'hD000_0008, 32'h0, 4'hF, r1);
    bus_access(1'b0, 32'hD000_0008, 32'h0, 4'hF, r2);
    if (r1 !== load_val || r2 !== load_val) begin
      $display("MISMATCH at %0t: stopped counter read %h/%h, loaded %h", $time, r1, r2, load_val);
      tb_errors++;
    end
    // Keep clear of the wrap point while counting
    bus_access(1'b1, 32'hD000_0008, {1'b0, load_val[30:0]}, 4'hF, r1);
    bus_access(1'b1, 32'hD000_0004, 32'h1, 4'h1, r1);
    bus_access(1'b0, 32'hD000_0008, 32'h0, 4'hF, r1);
    bus_access(1'b0, 32'hD000_0008, 32'h0, 4'hF, r2);
    if (!(r2 > r1) || (r2 - r1) > 32'd300) begin
      $display("MISMATCH at %0t: running counter read %h then %h", $time, r1, r2);
      tb_errors++;
    end
    bus_access(1'b1, 32'hD000_0004, 32'h0, 4'hF, r1);
  endtask

  initial begin
    int          mark;
    int          rst_cycles;
    logic [31:0] rdata;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    wb_req    = '0;
    apb_rsp   = '0;
    seed      = 32'he82a_b14f;
    wait_seed = seed ^ 32'h1357_9bdf;
    wait_left = 0;
    tb_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int i = 0; i < 1024; i++) uart_mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    rst_cycles = 0;
    while (rst_cycles < 5) begin
      @(negedge clk_i);
      rst_cycles++;
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);

    // Reads of untouched memory first
    mark = tb_errors + checker_errors;
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, gen_addr(0, $random(seed)), 32'h0, 4'hF, rdata);
    end
    random_traffic(0, 300, 1'b0);
    report_test("l2 memory", mark);
    mark = tb_errors + checker_errors;
    random_traffic(1, 120, 1'b0);
    report_test("control registers", mark);
    mark = tb_errors + checker_errors;
    counter_test();
    report_test("cycle counter", mark);
    mark = tb_errors + checker_errors;
    random_traffic(2, 80, 1'b1);
    report_test("uart writes", mark);
    mark = tb_errors + checker_errors;
    random_traffic(3, 150, 1'b0);
    report_test("uart reads and errors", mark);
    mark = tb_errors + checker_errors;
    random_traffic(4, 60, 1'b0);
    report_test("unmapped addresses", mark);

    $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
             tb_errors + checker_errors);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
